// File: source/mapper_settings.svh
// memory mapper settings

`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// system clocks per 68000 clock-enable pulse
// cpu_cenb lands half of this later
`define MAPPER_CEN_DIV 4

// register map
// index 3 holds the sound latch byte
`define MAPPER_REG_SOUND 3

// first region register
// region r: size/wait byte at 16+2r, base byte at 16+2r+1
// size/wait byte: bits 1:0 size, bits 3:2 wait code
`define MAPPER_REG_REGION 16

`endif

// File: source/mapper_pkg.sv
// memory mapper shared types

package mapper_pkg;

    // region size field, bits 1:0 of the size/wait byte
    // how many of addr[23:16] take part in the compare
    typedef enum logic [1:0] {
        // all 8 upper bits
        SIZE_64K  = 2'd0,
        // upper 7 bits
        SIZE_128K = 2'd1,
        // upper 5 bits
        SIZE_512K = 2'd2,
        // upper 3 bits only
        SIZE_2M   = 2'd3
    } region_size_e;

    // wait field, bits 3:2 of the size/wait byte
    // extra cpu_cen ticks added after the base DTACK
    typedef enum logic [1:0] {
        WAIT_0  = 2'd0,
        // EDACK code on the real part, no extra ticks here
        WAIT_0B = 2'd1,
        WAIT_1  = 2'd2,
        WAIT_2  = 2'd3
    } wait_code_e;

    // who may write the register file
    typedef enum logic {
        OWNER_CPU = 1'b0,
        OWNER_MCU = 1'b1
    } reg_owner_e;

endpackage

// File: source/mapper_regs.sv
// mapper register file and owner arbiter

`timescale 1ns/1ps

`include "mapper_settings.svh"

module mapper_regs import mapper_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // 68000 side
    input  logic [23:1]     addr,
    input  logic [15:0]     cpu_dout,
    input  logic [1:0]      cpu_dswn,
    input  logic            cpu_asn,
    // all zero means no region mapped
    input  logic [7:0]      active,
    // MCU side
    input  logic [15:0]     mcu_addr,
    input  logic [7:0]      mcu_dout,
    input  logic            mcu_wr,
    // sound CPU side
    input  logic            sndmap_rd,
    // status port
    input  logic [7:0]      st_addr,
    output logic [7:0][7:0] base_bytes,
    output logic [7:0][7:0] size_bytes,
    output logic [7:0]      sndmap_dout,
    output logic            sndmap_obf,
    output logic [7:0]      mcu_din,
    output logic [7:0]      st_dout
);

    logic [7:0] regs [32];
    reg_owner_e owner;
    logic       cpu_wr;
    logic       wr_en;
    logic [4:0] wr_idx;
    logic [7:0] wr_data;
    logic [4:0] st_idx;

    // low byte write from the 68000, only with nothing mapped
    assign cpu_wr = (owner == OWNER_CPU) && !cpu_asn && !cpu_dswn[0] && (active == 8'd0);

    // arbiter
    // MCU strobe always wins and locks the CPU out
    always_comb begin
        if (mcu_wr) begin
            wr_en   = 1'b1;
            wr_idx  = mcu_addr[4:0];
            wr_data = mcu_dout;
        end else begin
            wr_en   = cpu_wr;
            // word registers, byte lane 0
            wr_idx  = addr[5:1];
            wr_data = cpu_dout[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 8'd0;
            end
            owner      <= OWNER_CPU;
            sndmap_obf <= 1'b0;
        end else begin
            // one-way switch until the next reset
            if (mcu_wr) begin
                owner <= OWNER_MCU;
            end
            if (wr_en) begin
                regs[wr_idx] <= wr_data;
                // new byte for the sound CPU
                if (wr_idx == 5'(`MAPPER_REG_SOUND)) begin
                    sndmap_obf <= 1'b1;
                end
            end
            // sound CPU picked it up
            if (sndmap_rd) begin
                sndmap_obf <= 1'b0;
            end
        end
    end

    // region bytes out to the decoder
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            size_bytes[r] = regs[`MAPPER_REG_REGION + 2 * r];
            base_bytes[r] = regs[`MAPPER_REG_REGION + 2 * r + 1];
        end
    end

    assign sndmap_dout = regs[`MAPPER_REG_SOUND];

    // MCU reads back its own data bus
    assign mcu_din = mcu_dout;

    // status read
    // st_addr[2:0] region, st_addr[3] picks size (0) or base (1)
    assign st_idx = 5'(`MAPPER_REG_REGION) + {1'b0, st_addr[2:0], st_addr[3]};

    always_ff @(posedge clk) begin
        st_dout <= regs[st_idx];
    end

endmodule

// File: source/region_decode.sv
// mapper region priority decoder

`timescale 1ns/1ps

module region_decode import mapper_pkg::*; (
    input  logic [23:1]     addr,
    input  logic [2:0]      cpu_fc,
    input  logic [7:0][7:0] base_bytes,
    input  logic [7:0][7:0] size_bytes,
    // one-hot, lowest region wins
    output logic [7:0]      active,
    output wait_code_e      wait_code
);

    logic [7:0] upper;
    logic [7:0] hits;

    // compare width follows the region size
    function automatic logic region_hit(
        input logic [7:0] adr_hi,
        input logic [7:0] base,
        input logic [7:0] size_wait
    );
        region_size_e sz;
        logic         hit;
        sz = region_size_e'(size_wait[1:0]);
        case (sz)
            SIZE_64K:  hit = (adr_hi == base);
            SIZE_128K: hit = (adr_hi[7:1] == base[7:1]);
            SIZE_512K: hit = (adr_hi[7:3] == base[7:3]);
            default:   hit = (adr_hi[7:5] == base[7:5]);
        endcase
        return hit;
    endfunction

    assign upper = addr[23:16];

    // raw matches, several may hit at once
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            hits[r] = region_hit(upper, base_bytes[r], size_bytes[r]);
        end
    end

    // fixed priority
    // walk down so region 0 is the last to overwrite
    always_comb begin
        active    = 8'd0;
        wait_code = WAIT_0;
        // fc=7 is the interrupt acknowledge, nothing mapped
        if (cpu_fc != 3'b111) begin
            for (int r = 7; r >= 0; r--) begin
                if (hits[r]) begin
                    active    = 8'd1 << r;
                    wait_code = wait_code_e'(size_bytes[r][3:2]);
                end
            end
        end
    end

endmodule

// File: source/dtack_gen.sv
// 68000 clock enable and DTACK

`timescale 1ns/1ps

`include "mapper_settings.svh"

module dtack_gen import mapper_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_asn,
    input  logic [1:0] cpu_dsn,
    input  logic       bus_cs,
    input  logic       bus_busy,
    input  wait_code_e wait_code,
    output logic       cpu_cen,
    output logic       cpu_cenb,
    output logic       cpu_dtackn
);

    localparam int CEN_DIV = `MAPPER_CEN_DIV;
    localparam int CEN_HALF = CEN_DIV / 2;
    localparam int CNT_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [CNT_W-1:0] cen_cnt;
    logic             bus_act;
    logic             bus_hold;
    logic             dtackn_base;
    logic             dtackn_d1;
    logic             dtackn_d2;

    // integer divider
    // cen at the end of the count, cenb half a period away
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt  <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            if (cen_cnt == CNT_W'(CEN_DIV - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            cpu_cen  <= (cen_cnt == CNT_W'(CEN_DIV - 1));
            cpu_cenb <= (cen_cnt == CNT_W'(CEN_HALF - 1));
        end
    end

    // address strobe plus at least one data strobe
    assign bus_act = !cpu_asn && !(&cpu_dsn);

    // device still busy, keep DTACK off
    assign bus_hold = bus_cs && bus_busy;

    // base DTACK
    // drops on a cen tick, stays low for the rest of the cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn_base <= 1'b1;
        end else if (cpu_asn) begin
            dtackn_base <= 1'b1;
        end else if (cpu_cen && bus_act && !bus_hold) begin
            dtackn_base <= 1'b0;
        end
    end

    // wait states, one stage per cen tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn_d1 <= 1'b1;
            dtackn_d2 <= 1'b1;
        end else if (cpu_asn) begin
            dtackn_d1 <= 1'b1;
            dtackn_d2 <= 1'b1;
        end else if (cpu_cen) begin
            dtackn_d1 <= dtackn_base;
            dtackn_d2 <= dtackn_d1;
        end
    end

    // tap select by region wait code
    always_comb begin
        case (wait_code)
            WAIT_1:  cpu_dtackn = dtackn_d1;
            WAIT_2:  cpu_dtackn = dtackn_d2;
            // WAIT_0 and WAIT_0B
            default: cpu_dtackn = dtackn_base;
        endcase
    end

endmodule

// File: source/irq_ctrl.sv
// VBLANK interrupt control

`timescale 1ns/1ps

module irq_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic [2:0] cpu_fc,
    input  logic       cpu_asn,
    output logic [2:0] cpu_ipln,
    output logic       cpu_vpan,
    output logic [1:0] mcu_intn
);

    logic vint_last;
    logic irqn;
    logic inta;

    // interrupt acknowledge cycle
    assign inta = (&cpu_fc) && !cpu_asn;

    // autovector request during the ack
    assign cpu_vpan = !inta;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_last <= 1'b0;
            irqn      <= 1'b1;
        end else begin
            vint_last <= vint;
            // ack has priority over a new edge
            if (inta) begin
                irqn <= 1'b1;
            end else if (vint && !vint_last) begin
                irqn <= 1'b0;
            end
        end
    end

    // level 4, active low encoding 011
    assign cpu_ipln = {irqn, 2'b11};

    // bit 1 unused on the MCU side
    assign mcu_intn = {1'b1, irqn};

endmodule

// File: source/mapper_top.sv
// 68000 memory mapper top level

`timescale 1ns/1ps

module mapper_top import mapper_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // 68000 bus
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  cpu_dswn,
    input  logic [1:0]  cpu_dsn,
    input  logic        cpu_asn,
    input  logic [2:0]  cpu_fc,
    input  logic        vint,
    input  logic        bus_cs,
    input  logic        bus_busy,
    output logic        cpu_cen,
    output logic        cpu_cenb,
    output logic        cpu_dtackn,
    output logic [2:0]  cpu_ipln,
    output logic        cpu_vpan,
    // MCU
    input  logic [15:0] mcu_addr,
    input  logic [7:0]  mcu_dout,
    input  logic        mcu_wr,
    output logic [7:0]  mcu_din,
    output logic [1:0]  mcu_intn,
    // sound CPU, only the read strobe reaches the latch
    input  logic        sndmap_rd,
    input  logic        sndmap_wr,
    output logic [7:0]  sndmap_dout,
    output logic        sndmap_obf,
    // board bus side
    output logic [7:0]  active,
    // status dump
    input  logic [7:0]  st_addr,
    output logic [7:0]  st_dout
);

    logic [7:0][7:0] base_bytes;
    logic [7:0][7:0] size_bytes;
    wait_code_e      wait_code;

    mapper_regs regs_i (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .cpu_dswn    (cpu_dswn),
        .cpu_asn     (cpu_asn),
        .active      (active),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .sndmap_rd   (sndmap_rd),
        .st_addr     (st_addr),
        .base_bytes  (base_bytes),
        .size_bytes  (size_bytes),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf),
        .mcu_din     (mcu_din),
        .st_dout     (st_dout)
    );

    region_decode decode_i (
        .addr       (addr),
        .cpu_fc     (cpu_fc),
        .base_bytes (base_bytes),
        .size_bytes (size_bytes),
        .active     (active),
        .wait_code  (wait_code)
    );

    dtack_gen dtack_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_asn    (cpu_asn),
        .cpu_dsn    (cpu_dsn),
        .bus_cs     (bus_cs),
        .bus_busy   (bus_busy),
        .wait_code  (wait_code),
        .cpu_cen    (cpu_cen),
        .cpu_cenb   (cpu_cenb),
        .cpu_dtackn (cpu_dtackn)
    );

    irq_ctrl irq_i (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .cpu_fc   (cpu_fc),
        .cpu_asn  (cpu_asn),
        .cpu_ipln (cpu_ipln),
        .cpu_vpan (cpu_vpan),
        .mcu_intn (mcu_intn)
    );

endmodule

// File: tb/mapper_props.sv
// mapper bus and interrupt properties

`timescale 1ns/1ps

module mapper_props (
    input logic       clk,
    input logic       rst,
    input logic       cpu_asn,
    input logic       cpu_cen,
    input logic       cpu_dtackn,
    input logic       vint,
    input logic [2:0] cpu_fc,
    input logic [2:0] cpu_ipln
);

    int   fail_cnt = 0;
    logic inta;

    // acknowledge cycle, fc 7 under the address strobe
    assign inta = (&cpu_fc) && !cpu_asn;

    // DTACK released one clock after the strobe ends
    dtack_release: assert property (@(posedge clk) disable iff (rst)
        cpu_asn |=> cpu_dtackn)
        else begin fail_cnt++; $error("cpu_dtackn low after strobe release"); end

    // every DTACK fall follows a cen tick
    dtack_on_cen: assert property (@(posedge clk) disable iff (rst)
        $fell(cpu_dtackn) |-> $past(cpu_cen))
        else begin fail_cnt++; $error("cpu_dtackn fell without cpu_cen"); end

    irq_on_edge: assert property (@(posedge clk) disable iff (rst)
        ($rose(vint) && !inta) |=> !cpu_ipln[2])
        else begin fail_cnt++; $error("vint edge gave no level 4 request"); end

    irq_ack: assert property (@(posedge clk) disable iff (rst)
        inta |=> cpu_ipln[2])
        else begin fail_cnt++; $error("request held after acknowledge"); end

endmodule

bind mapper_top mapper_props props_i (
    .clk        (clk),
    .rst        (rst),
    .cpu_asn    (cpu_asn),
    .cpu_cen    (cpu_cen),
    .cpu_dtackn (cpu_dtackn),
    .vint       (vint),
    .cpu_fc     (cpu_fc),
    .cpu_ipln   (cpu_ipln)
);

// File: tb/mapper_tb.sv
// memory mapper testbench

`timescale 1ns/1ps

`include "mapper_settings.svh"

module mapper_tb import mapper_pkg::*; ();

    localparam int CLK_NS = 10;
    localparam int CEN_DIV = `MAPPER_CEN_DIV;
    // worst single bus access, busy hold and release included
    localparam int ACCESS_CYCLES = 8 * CEN_DIV + 8;
    localparam int ACCESS_COUNT = 48;
    // reset, status reads, decode checks, interrupt
    localparam int OTHER_CYCLES = 400;
    localparam int WATCHDOG_NS = 2 * (ACCESS_COUNT * ACCESS_CYCLES + OTHER_CYCLES) * CLK_NS;
    localparam int DTACK_LIMIT = 6 * CEN_DIV;
    // upper address byte kept clear of every region
    localparam logic [7:0] REG_WINDOW = 8'hFF;

    logic        clk;
    logic        rst;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0]  cpu_dswn;
    logic [1:0]  cpu_dsn;
    logic        cpu_asn;
    logic [2:0]  cpu_fc;
    logic        vint;
    logic        bus_cs;
    logic        bus_busy;
    logic        cpu_cen;
    logic        cpu_cenb;
    logic        cpu_dtackn;
    logic [2:0]  cpu_ipln;
    logic        cpu_vpan;
    logic [15:0] mcu_addr;
    logic [7:0]  mcu_dout;
    logic        mcu_wr;
    logic [7:0]  mcu_din;
    logic [1:0]  mcu_intn;
    logic        sndmap_rd;
    logic        sndmap_wr;
    logic [7:0]  sndmap_dout;
    logic        sndmap_obf;
    logic [7:0]  active;
    logic [7:0]  st_addr;
    logic [7:0]  st_dout;

    // expected region registers
    logic [7:0]  model_size [8];
    logic [7:0]  model_base [8];
    logic [15:0] lfsr_state;

    mapper_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: no result after %0d ns", WATCHDOG_NS);
        end_with_failure();
    end

    // bound properties
    initial begin
        wait (dut_i.props_i.fail_cnt != 0);
        $display("bound assertion failed at %0t ns", $time);
        end_with_failure();
    end

    task automatic end_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    task automatic check_active(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: active got %08b expected %08b", $time, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // cen ticks from strobe to DTACK, one base tick plus the wait states
    task automatic check_wait(input wait_code_e code, input int ticks);
        int exp_ticks;
        case (code)
            WAIT_1:  exp_ticks = 2;
            WAIT_2:  exp_ticks = 3;
            default: exp_ticks = 1;
        endcase
        if (ticks != exp_ticks) begin
            $display("** Error at %0t ns: cpu_dtackn ticks (%s) got %0d expected %0d",
                     $time, code.name(), ticks, exp_ticks);
            end_with_failure();
        end
    endtask

    // lowest region whose top bits match, 8/7/5/3 bits by size
    function automatic logic [7:0] model_active(input logic [7:0] upper, input logic [2:0] fc);
        int         bits;
        logic [7:0] mask;
        if (fc == 3'd7) begin
            return 8'd0;
        end
        for (int r = 0; r < 8; r++) begin
            case (region_size_e'(model_size[r][1:0]))
                SIZE_64K:  bits = 8;
                SIZE_128K: bits = 7;
                SIZE_512K: bits = 5;
                default:   bits = 3;
            endcase
            mask = 8'hFF << (8 - bits);
            if (((upper ^ model_base[r]) & mask) == 8'd0) begin
                return 8'd1 << r;
            end
        end
        return 8'd0;
    endfunction

    function automatic wait_code_e model_wait(input logic [7:0] upper);
        logic [7:0] hit;
        hit = model_active(upper, 3'd5);
        for (int r = 0; r < 8; r++) begin
            if (hit[r]) begin
                return wait_code_e'(model_size[r][3:2]);
            end
        end
        return WAIT_0;
    endfunction

    // cen one clock in CEN_DIV, cenb half a period after it
    task automatic cen_phase_check();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cpu_cen) begin
            cycles++;
            if (cycles > CEN_DIV) begin
                $display("cpu_cen did not pulse within %0d clocks", CEN_DIV);
                end_with_failure();
            end
            @(negedge clk);
        end
        check_level("cpu_cenb", cpu_cenb, 1'b0);
        for (int i = 1; i < CEN_DIV; i++) begin
            @(negedge clk);
            check_level("cpu_cen", cpu_cen, 1'b0);
            check_level("cpu_cenb", cpu_cenb, (i == CEN_DIV / 2));
        end
        @(negedge clk);
        check_level("cpu_cen", cpu_cen, 1'b1);
    endtask

    // counts cen pulses until DTACK, sampled on the falling edge
    task automatic wait_dtack(output int ticks);
        int cycles;
        ticks = 0;
        cycles = 0;
        @(negedge clk);
        while (cpu_dtackn) begin
            if (cpu_cen) begin
                ticks++;
            end
            cycles++;
            if (cycles > DTACK_LIMIT) begin
                $display("DTACK did not come within %0d clocks of the strobe", DTACK_LIMIT);
                end_with_failure();
            end
            @(negedge clk);
        end
    endtask

    // release strobes, DTACK must be back high a clock later
    task automatic end_access();
        @(posedge clk);
        cpu_asn  <= 1'b1;
        cpu_dsn  <= 2'b11;
        cpu_dswn <= 2'b11;
        @(posedge clk);
        @(negedge clk);
        check_level("cpu_dtackn", cpu_dtackn, 1'b1);
    endtask

    task automatic cpu_access(input logic [23:0] byte_addr, input logic [15:0] data,
                              input logic write, output int ticks);
        @(posedge clk);
        addr     <= byte_addr[23:1];
        cpu_fc   <= 3'd5;
        cpu_dout <= data;
        @(posedge clk);
        cpu_asn  <= 1'b0;
        cpu_dsn  <= 2'b10;
        cpu_dswn <= write ? 2'b10 : 2'b11;
        wait_dtack(ticks);
        end_access();
    endtask

    task automatic cpu_write_reg(input int idx, input logic [7:0] data);
        int ticks;
        cpu_access({REG_WINDOW, 16'h0000} | 24'(idx << 1), {8'h00, data}, 1'b1, ticks);
    endtask

    task automatic program_region(input int r, input region_size_e size,
                                  input wait_code_e wcode, input logic [7:0] base);
        cpu_write_reg(`MAPPER_REG_REGION + 2 * r, {4'h0, wcode, size});
        cpu_write_reg(`MAPPER_REG_REGION + 2 * r + 1, base);
        model_size[r] = {4'h0, wcode, size};
        model_base[r] = base;
    endtask

    task automatic mcu_write(input int idx, input logic [7:0] data);
        @(posedge clk);
        mcu_addr <= 16'(idx);
        mcu_dout <= data;
        mcu_wr   <= 1'b1;
        @(posedge clk);
        mcu_wr   <= 1'b0;
        @(negedge clk);
        check_byte("mcu_din", mcu_din, data);
    endtask

    task automatic status_read(input logic [7:0] sel, output logic [7:0] data);
        @(posedge clk);
        st_addr <= sel;
        @(posedge clk);
        @(negedge clk);
        data = st_dout;
    endtask

    task automatic check_decode(input logic [7:0] upper, input logic [2:0] fc);
        @(posedge clk);
        addr   <= {upper, 15'h0000};
        cpu_fc <= fc;
        @(negedge clk);
        check_active(active, model_active(upper, fc));
    endtask

    // bus_cs with bus_busy holds DTACK off, count restarts on release
    task automatic busy_access(input logic [23:0] byte_addr);
        int ticks;
        @(posedge clk);
        addr   <= byte_addr[23:1];
        cpu_fc <= 3'd5;
        @(posedge clk);
        cpu_asn  <= 1'b0;
        cpu_dsn  <= 2'b10;
        bus_cs   <= 1'b1;
        bus_busy <= 1'b1;
        repeat (4 * CEN_DIV) begin
            @(negedge clk);
            check_level("cpu_dtackn", cpu_dtackn, 1'b1);
        end
        @(posedge clk);
        bus_cs   <= 1'b0;
        bus_busy <= 1'b0;
        wait_dtack(ticks);
        check_wait(model_wait(byte_addr[23:16]), ticks);
        end_access();
    endtask

    // one clock interrupt acknowledge, fc 7
    task automatic ack_cycle();
        @(posedge clk);
        addr    <= 23'h7FFFFF;
        cpu_fc  <= 3'd7;
        cpu_asn <= 1'b0;
        @(negedge clk);
        check_level("cpu_vpan", cpu_vpan, 1'b0);
        check_active(active, 8'd0);
        @(posedge clk);
        cpu_asn <= 1'b1;
        cpu_fc  <= 3'd5;
        @(negedge clk);
        check_level("cpu_vpan", cpu_vpan, 1'b1);
        check_level("cpu_ipln[2]", cpu_ipln[2], 1'b1);
        check_level("mcu_intn[0]", mcu_intn[0], 1'b1);
    endtask

    task automatic test_reset();
        logic [7:0] data;
        @(negedge clk);
        check_level("cpu_dtackn", cpu_dtackn, 1'b1);
        check_level("cpu_ipln[2]", cpu_ipln[2], 1'b1);
        check_level("cpu_vpan", cpu_vpan, 1'b1);
        check_level("mcu_intn[0]", mcu_intn[0], 1'b1);
        check_level("sndmap_obf", sndmap_obf, 1'b0);
        for (int i = 0; i < 16; i++) begin
            status_read(8'(i), data);
            check_byte("st_dout", data, 8'h00);
        end
        cen_phase_check();
    endtask

    task automatic test_regions();
        logic [7:0] data;
        logic [7:0] picks [6];
        picks = '{8'h10, 8'h21, 8'h25, 8'h47, 8'hA1, 8'hFF};
        // overlaps on purpose, 0 over 4 and 1 over 5
        program_region(0, SIZE_64K, WAIT_0, 8'h10);
        program_region(1, SIZE_128K, WAIT_0B, 8'h20);
        program_region(2, SIZE_512K, WAIT_1, 8'h40);
        program_region(3, SIZE_2M, WAIT_2, 8'h60);
        program_region(4, SIZE_2M, WAIT_1, 8'h00);
        program_region(5, SIZE_512K, WAIT_2, 8'h20);
        program_region(6, SIZE_64K, WAIT_0, 8'h80);
        program_region(7, SIZE_128K, WAIT_1, 8'hA0);
        for (int r = 0; r < 8; r++) begin
            status_read(8'(r), data);
            check_byte("st_dout size", data, model_size[r]);
            status_read(8'(r) | 8'h08, data);
            check_byte("st_dout base", data, model_base[r]);
        end
        foreach (picks[i]) begin
            check_decode(picks[i], 3'd5);
        end
        // every sixth random address as an acknowledge cycle
        for (int n = 0; n < 24; n++) begin
            check_decode(lfsr_byte(), (n % 6 == 5) ? 3'd7 : 3'd5);
        end
    endtask

    task automatic test_dtack();
        int         ticks;
        logic [7:0] picks [5];
        picks = '{8'hFF, 8'h10, 8'h20, 8'h44, 8'h70};
        foreach (picks[i]) begin
            cpu_access({picks[i], 16'h0000}, 16'h0000, 1'b0, ticks);
            check_wait(model_wait(picks[i]), ticks);
        end
        busy_access(24'h700000);
    endtask

    task automatic test_sound();
        check_level("sndmap_obf", sndmap_obf, 1'b0);
        cpu_write_reg(`MAPPER_REG_SOUND, 8'h5A);
        check_byte("sndmap_dout", sndmap_dout, 8'h5A);
        check_level("sndmap_obf", sndmap_obf, 1'b1);
        @(posedge clk);
        sndmap_rd <= 1'b1;
        @(posedge clk);
        sndmap_rd <= 1'b0;
        @(negedge clk);
        check_level("sndmap_obf", sndmap_obf, 1'b0);
    endtask

    task automatic test_owner();
        int         ticks;
        logic [7:0] data;
        // register 3 lane inside region 0, write ignored
        cpu_access(24'h100006, 16'h00E1, 1'b1, ticks);
        check_byte("sndmap_dout", sndmap_dout, 8'h5A);
        check_level("sndmap_obf", sndmap_obf, 1'b0);
        mcu_write(`MAPPER_REG_SOUND, 8'hC3);
        check_byte("sndmap_dout", sndmap_dout, 8'hC3);
        // CPU now locked out
        cpu_write_reg(`MAPPER_REG_SOUND, 8'h77);
        check_byte("sndmap_dout", sndmap_dout, 8'hC3);
        mcu_write(`MAPPER_REG_REGION + 13, 8'hB0);
        model_base[6] = 8'hB0;
        cpu_write_reg(`MAPPER_REG_REGION + 13, 8'h33);
        status_read(8'h0E, data);
        check_byte("st_dout base", data, model_base[6]);
    endtask

    task automatic test_irq();
        @(posedge clk);
        vint <= 1'b1;
        @(negedge clk);
        check_level("cpu_ipln[2]", cpu_ipln[2], 1'b1);
        @(negedge clk);
        check_level("cpu_ipln[2]", cpu_ipln[2], 1'b0);
        // level 4 is 011 active low
        check_level("cpu_ipln[1]", cpu_ipln[1], 1'b1);
        check_level("cpu_ipln[0]", cpu_ipln[0], 1'b1);
        check_level("mcu_intn[0]", mcu_intn[0], 1'b0);
        check_level("mcu_intn[1]", mcu_intn[1], 1'b1);
        ack_cycle();
        // vint still high, no new request
        repeat (8) begin
            @(negedge clk);
            check_level("cpu_ipln[2]", cpu_ipln[2], 1'b1);
        end
        @(posedge clk);
        vint <= 1'b0;
    endtask

    initial begin
        lfsr_state = 16'd46;
        rst       = 1'b1;
        addr      = '0;
        cpu_dout  = '0;
        cpu_dswn  = 2'b11;
        cpu_dsn   = 2'b11;
        cpu_asn   = 1'b1;
        cpu_fc    = 3'd5;
        vint      = 1'b0;
        bus_cs    = 1'b0;
        bus_busy  = 1'b0;
        mcu_addr  = '0;
        mcu_dout  = '0;
        mcu_wr    = 1'b0;
        sndmap_rd = 1'b0;
        sndmap_wr = 1'b0;
        st_addr   = '0;
        for (int r = 0; r < 8; r++) begin
            model_size[r] = 8'd0;
            model_base[r] = 8'd0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_regions();
        test_dtack();
        test_sound();
        test_owner();
        test_irq();
        repeat (4) @(posedge clk);
        if (dut_i.props_i.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut_i.props_i.fail_cnt);
            $display("STATUS: FAIL");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

// File: tb.f
+incdir+source
source/mapper_pkg.sv
source/mapper_regs.sv
source/region_decode.sv
source/dtack_gen.sv
source/irq_ctrl.sv
source/mapper_top.sv
tb/mapper_props.sv
tb/mapper_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module mapper_tb -o mapper_sim

output=$(./obj_dir/mapper_sim +verilator+error+limit+1000 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
